/* compile.f */
logic/mmio_pkg.sv
logic/mmio_router.sv
logic/data_ram.sv
logic/uart_tx_port.sv
logic/uart_rx_port.sv
logic/timer_port.sv
logic/mmio_top.sv
bench/tb_clock.sv
bench/mmio_tb.sv

/* bench/mmio_tb.sv */
module mmio_tb;
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic [31:0]       addr;
        logic              wen;
        logic [31:0]       wdata;
        logic [3:0]        mask;
        logic [31:0]       exp_data;
        logic              exp_err;
        mmio_pkg::err_kind exp_kind;
        logic              wait_pend;
    } row_t;

    logic              clk;
    logic              reset;
    logic              dreq_valid;
    logic              dreq_ready;
    logic [31:0]       dreq_addr;
    logic              dreq_wen;
    logic [31:0]       dreq_wdata;
    logic [3:0]        dreq_wmask;
    logic              dresp_valid;
    logic [31:0]       dresp_rdata;
    logic              dresp_error;
    mmio_pkg::err_kind dresp_errty;
    logic              uart_line;
    logic              uart_rx_pending;
    logic              mti_pending;

    row_t        rows[$];
    logic [31:0] ram_model [mmio_pkg::ram_words];
    logic [31:0] lcg_state = 32'd65;
    int          cycles = 0;
    int          cycle_limit = 100000;
    int          data_errors = 0;
    int          status_errors = 0;
    int          timing_errors = 0;

    tb_clock clock_gen (.clk);

    // The transmit line feeds the receive line directly.
    mmio_top UUT (
        .clk, .reset, .dreq_valid, .dreq_ready, .dreq_addr, .dreq_wen, .dreq_wdata,
        .dreq_wmask, .dresp_valid, .dresp_rdata, .dresp_error, .dresp_errty,
        .uart_rx(uart_line), .uart_tx(uart_line), .uart_rx_pending, .mti_pending
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("The run timed out after %0d cycles before all rows were done.", cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  mask);
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (mask[b])
                result[8*b +: 8] = new_word[8*b +: 8];
        end
        return result;
    endfunction

    task automatic add_row(input logic [31:0] addr, input logic wen, input logic [31:0] wdata,
                           input logic [3:0] mask, input logic [31:0] exp_data,
                           input mmio_pkg::err_kind exp_kind, input logic wait_pend);
        rows.push_back('{addr, wen, wdata, mask, exp_data, exp_kind != mmio_pkg::none,
                         exp_kind, wait_pend});
    endtask

    task automatic add_ram_write(input int word, input logic [31:0] data, input logic [3:0] mask);
        ram_model[word] = merge_bytes(ram_model[word], data, mask);
        add_row(word * 4, 1'b1, data, mask, 32'h0, mmio_pkg::none, 1'b0);
    endtask

    //////////////////////////////////////////////////
    // Stimulus table
    //////////////////////////////////////////////////

    task automatic build_table();
        int          words[6];
        logic [3:0]  mask;
        logic [7:0]  byte_a;
        logic [7:0]  byte_b;
        for (int i = 0; i < 6; i++) begin
            words[i] = i * 170 + int'((lcg_next() >> 16) % 170);
            add_ram_write(words[i], lcg_next(), 4'hf);
        end
        for (int i = 0; i < 6; i++) begin
            mask = 4'(lcg_next() >> 28);
            add_ram_write(words[i], lcg_next(), mask);
        end
        for (int i = 0; i < 6; i++)
            add_row(words[i] * 4, 1'b0, '0, '0, ram_model[words[i]], mmio_pkg::none, 1'b0);
        // Both faulting writes alias word 0 if they were stored.
        add_ram_write(0, lcg_next(), 4'hf);
        add_row(mmio_pkg::ram_bytes, 1'b1, lcg_next(), 4'hf, '0, mmio_pkg::access_fault, 1'b0);
        add_row(2 * mmio_pkg::ram_bytes, 1'b0, '0, '0, '0, mmio_pkg::access_fault, 1'b0);
        add_row(32'h2, 1'b1, lcg_next(), 4'hf, '0, mmio_pkg::misaligned, 1'b0);
        add_row(32'h0, 1'b0, '0, '0, ram_model[0], mmio_pkg::none, 1'b0);
        byte_a = 8'(lcg_next() >> 24);
        byte_b = 8'(lcg_next() >> 24);
        add_row(mmio_pkg::uart_tx_base, 1'b1, {24'h0, byte_a}, 4'h1, '0, mmio_pkg::none, 1'b0);
        add_row(mmio_pkg::uart_tx_base, 1'b1, {24'h0, byte_b}, 4'h1, '0, mmio_pkg::none, 1'b0);
        add_row(mmio_pkg::uart_rx_base, 1'b0, '0, '0, {24'h0, byte_a}, mmio_pkg::none, 1'b1);
        add_row(mmio_pkg::uart_rx_base + 4, 1'b0, '0, '0, '0, mmio_pkg::none, 1'b0);
        add_row(mmio_pkg::uart_rx_base, 1'b0, '0, '0, {24'h0, byte_b}, mmio_pkg::none, 1'b1);
        add_row(mmio_pkg::uart_rx_base + 4, 1'b0, '0, '0, '0, mmio_pkg::none, 1'b0);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // resp_cycle is the edge at which the processor takes the response.
    task automatic run_access(input logic [31:0] addr, input logic wen,
                              input logic [31:0] wdata, input logic [3:0] mask,
                              output logic [31:0] rdata, output logic err,
                              output mmio_pkg::err_kind kind,
                              output int accept_cycle, output int resp_cycle);
        dreq_valid = 1'b1;
        dreq_addr  = addr;
        dreq_wen   = wen;
        dreq_wdata = wdata;
        dreq_wmask = mask;
        while (!dreq_ready)
            next_cycle();
        next_cycle();
        accept_cycle = cycles;
        dreq_valid   = 1'b0;
        while (!dresp_valid)
            next_cycle();
        resp_cycle = cycles + 1;
        rdata = dresp_rdata;
        err   = dresp_error;
        kind  = dresp_errty;
        if (!dreq_ready) begin
            timing_errors++;
            $display("** Error at %0t: dreq_ready is low while dresp_valid is high", $time);
        end
    endtask

    task automatic check_response(input row_t r, input logic [31:0] rdata, input logic err,
                                  input mmio_pkg::err_kind kind);
        if ((!r.wen || r.exp_err) && rdata !== r.exp_data) begin
            data_errors++;
            $display("** Error at %0t: address %h returned data %h, expected %h",
                     $time, r.addr, rdata, r.exp_data);
        end
        if (err !== r.exp_err || kind !== r.exp_kind) begin
            status_errors++;
            $display("** Error at %0t: address %h returned error %b kind %0d, expected %b kind %0d",
                     $time, r.addr, err, kind, r.exp_err, r.exp_kind);
        end
    endtask

    //////////////////////////////////////////////////
    // Timer compare
    //////////////////////////////////////////////////

    task automatic check_timer();
        logic [31:0]       lo;
        logic [31:0]       hi;
        logic [31:0]       rdata;
        logic [63:0]       cmp;
        logic              err;
        mmio_pkg::err_kind kind;
        int                t_accept;
        int                acc;
        int                w_resp;
        run_access(mmio_pkg::timer_base, 1'b0, '0, '0, lo, err, kind, t_accept, w_resp);
        run_access(mmio_pkg::timer_base + 4, 1'b0, '0, '0, hi, err, kind, acc, w_resp);
        cmp = {hi, lo} + 64'd200;
        run_access(mmio_pkg::timer_base + 8, 1'b1, cmp[31:0], 4'hf, rdata, err, kind, acc, w_resp);
        run_access(mmio_pkg::timer_base + 12, 1'b1, cmp[63:32], 4'hf, rdata, err, kind, acc,
                   w_resp);
        if (mti_pending !== 1'b0) begin
            timing_errors++;
            $display("** Error at %0t: mti_pending is %b right after the compare write",
                     $time, mti_pending);
        end
        run_access(mmio_pkg::timer_base + 8, 1'b0, '0, '0, rdata, err, kind, acc, acc);
        if (rdata !== cmp[31:0]) begin
            data_errors++;
            $display("** Error at %0t: compare low reads %h, expected %h", $time, rdata, cmp[31:0]);
        end
        while (!mti_pending && cycles - w_resp < 260)
            next_cycle();
        if (!mti_pending) begin
            timing_errors++;
            $display("mti_pending did not rise within 260 cycles of the compare write.");
        end else if (cycles - t_accept < 199) begin
            timing_errors++;
            $display("** Error at %0t: mti_pending rose %0d cycles after the time read",
                     $time, cycles - t_accept);
        end
    endtask

    initial begin
        row_t              r;
        logic [31:0]       rdata;
        logic              err;
        mmio_pkg::err_kind kind;
        int                accept_cycle;
        int                resp_cycle;
        int                tx_start_cycle;
        int                ref_cycle;
        int                tx_resp[$];
        reset          = 1'b1;
        dreq_valid     = 1'b0;
        dreq_addr      = '0;
        dreq_wen       = 1'b0;
        dreq_wdata     = '0;
        dreq_wmask     = '0;
        tx_start_cycle = -1000;
        build_table();
        cycle_limit = rows.size() * 100;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        if (dresp_valid !== 1'b0 || dreq_ready !== 1'b1 || uart_line !== 1'b1
                || uart_rx_pending !== 1'b0 || mti_pending !== 1'b0) begin
            status_errors++;
            $display("** Error at %0t: outputs are not in their reset state", $time);
        end
        foreach (rows[i]) begin
            r = rows[i];
            if (r.wait_pend) begin
                ref_cycle = tx_resp.pop_front();
                while (!uart_rx_pending && cycles - ref_cycle <= 60)
                    next_cycle();
                if (!uart_rx_pending) begin
                    timing_errors++;
                    $display("uart_rx_pending stayed low 60 cycles after the transmit write.");
                end
            end
            run_access(r.addr, r.wen, r.wdata, r.mask, rdata, err, kind, accept_cycle, resp_cycle);
            check_response(r, rdata, err, kind);
            // A transmit write issued during a frame must wait until that frame ends.
            if (r.addr == mmio_pkg::uart_tx_base && accept_cycle - tx_start_cycle < 40) begin
                if (resp_cycle - tx_start_cycle <= 40) begin
                    timing_errors++;
                    $display("** Error at %0t: transmit write done at cycle %0d, frame began at %0d",
                             $time, resp_cycle, tx_start_cycle);
                end
            end else if (resp_cycle - accept_cycle != 1) begin
                timing_errors++;
                $display("** Error at %0t: address %h responded after %0d cycles, expected 1",
                         $time, r.addr, resp_cycle - accept_cycle);
            end
            if (r.addr == mmio_pkg::uart_tx_base) begin
                tx_start_cycle = resp_cycle - 1;
                tx_resp.push_back(resp_cycle);
            end
        end
        check_timer();
        next_cycle();
        $display("Rows %0d, data errors %0d, status errors %0d, timing errors %0d",
                 rows.size(), data_errors, status_errors, timing_errors);
        if (data_errors + status_errors + timing_errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

/* bench/tb_clock.sv */
module tb_clock (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    // 4 ns period, first rising edge at 2 ns.
    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;

endmodule

/* logic/mmio_top.sv */
module mmio_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          dreq_valid,
    output logic                          dreq_ready,
    input  logic [mmio_pkg::xlen-1:0]     dreq_addr,
    input  logic                          dreq_wen,
    input  logic [mmio_pkg::xlen-1:0]     dreq_wdata,
    input  logic [mmio_pkg::xlen/8-1:0]   dreq_wmask,
    output logic                          dresp_valid,
    output logic [mmio_pkg::xlen-1:0]     dresp_rdata,
    output logic                          dresp_error,
    output mmio_pkg::err_kind             dresp_errty,
    input  logic                          uart_rx,
    output logic                          uart_tx,
    output logic                          uart_rx_pending,
    output logic                          mti_pending
);

    logic                          ram_start, ram_ready, ram_resp_valid, ram_error;
    logic [mmio_pkg::xlen-1:0]     ram_resp_rdata;
    mmio_pkg::err_kind             ram_errty;
    logic                          tx_start, tx_ready, tx_resp_valid;
    logic [mmio_pkg::xlen-1:0]     tx_resp_rdata;
    logic                          rx_start, rx_ready, rx_resp_valid;
    logic [mmio_pkg::xlen-1:0]     rx_resp_rdata;
    logic                          timer_start, timer_ready, timer_resp_valid;
    logic [mmio_pkg::xlen-1:0]     timer_resp_rdata;
    logic [mmio_pkg::xlen-1:0]     req_addr;
    logic                          req_wen;
    logic [mmio_pkg::xlen-1:0]     req_wdata;
    logic [mmio_pkg::xlen/8-1:0]   req_wmask;

    mmio_router router (.*);

    data_ram ram (
        .clk, .reset,
        .req_valid(ram_start), .req_ready(ram_ready), .req_addr, .req_wen,
        .req_wdata, .req_wmask,
        .resp_valid(ram_resp_valid), .resp_rdata(ram_resp_rdata),
        .resp_error(ram_error), .resp_errty(ram_errty)
    );

    uart_tx_port tx_port (
        .clk, .reset,
        .req_valid(tx_start), .req_ready(tx_ready), .req_wen,
        .req_wdata(req_wdata[7:0]),
        .resp_valid(tx_resp_valid), .resp_rdata(tx_resp_rdata),
        .uart_tx
    );

    uart_rx_port rx_port (
        .clk, .reset,
        .req_valid(rx_start), .req_ready(rx_ready), .req_addr(req_addr[3:0]),
        .resp_valid(rx_resp_valid), .resp_rdata(rx_resp_rdata),
        .uart_rx, .uart_rx_pending
    );

    timer_port timer (
        .clk, .reset,
        .req_valid(timer_start), .req_ready(timer_ready), .req_addr(req_addr[3:0]),
        .req_wen, .req_wdata,
        .resp_valid(timer_resp_valid), .resp_rdata(timer_resp_rdata),
        .mti_pending
    );

endmodule

/* logic/timer_port.sv */
module timer_port (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        req_valid,
    output logic                        req_ready,
    input  logic [3:0]                  req_addr,
    input  logic                        req_wen,
    input  logic [mmio_pkg::xlen-1:0]   req_wdata,
    output logic                        resp_valid,
    output logic [mmio_pkg::xlen-1:0]   resp_rdata,
    output logic                        mti_pending
);

    logic [63:0] mtime;
    logic [63:0] mtimecmp;

    assign req_ready   = 1'b1;
    assign mti_pending = (mtime >= mtimecmp);

    // A write to a time half overrides the increment for that half only.
    always_ff @(posedge clk) begin
        if (reset) begin
            mtime    <= '0;
            mtimecmp <= '1;
        end else begin
            mtime <= mtime + 64'd1;
            if (req_valid && req_wen) begin
                case (req_addr)
                    4'h0:    mtime[31:0]     <= req_wdata;
                    4'h4:    mtime[63:32]    <= req_wdata;
                    4'h8:    mtimecmp[31:0]  <= req_wdata;
                    4'hc:    mtimecmp[63:32] <= req_wdata;
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            resp_valid <= 1'b0;
        else
            resp_valid <= req_valid;
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            case (req_addr)
                4'h0:    resp_rdata <= mtime[31:0];
                4'h4:    resp_rdata <= mtime[63:32];
                4'h8:    resp_rdata <= mtimecmp[31:0];
                4'hc:    resp_rdata <= mtimecmp[63:32];
                default: resp_rdata <= '0;
            endcase
        end
    end

endmodule

/* logic/uart_rx_port.sv */
module uart_rx_port (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        req_valid,
    output logic                        req_ready,
    input  logic [3:0]                  req_addr,
    output logic                        resp_valid,
    output logic [mmio_pkg::xlen-1:0]   resp_rdata,
    input  logic                        uart_rx,
    output logic                        uart_rx_pending
);

    logic [1:0]                         rx_sync;
    logic                               rx_prev;
    logic                               active;
    logic                               sample;
    logic [3:0]                         bit_cnt;
    logic [mmio_pkg::uart_div_bits-1:0] div_cnt;
    logic [7:0]                         shift;
    logic [7:0]                         rx_byte;

    assign req_ready = 1'b1;
    assign sample    = active
        && div_cnt == mmio_pkg::uart_div_bits'(mmio_pkg::uart_divisor / 2 - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_sync <= 2'b11;
            rx_prev <= 1'b1;
        end else begin
            rx_sync <= {rx_sync[0], uart_rx};
            rx_prev <= rx_sync[1];
        end
    end

    //////////////////////////////////////////////////
    // Bit sampler
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            active          <= 1'b0;
            bit_cnt         <= '0;
            div_cnt         <= '0;
            uart_rx_pending <= 1'b0;
        end else begin
            if (req_valid && req_addr == 4'h0)
                uart_rx_pending <= 1'b0;
            if (!active) begin
                if (rx_prev && !rx_sync[1]) begin
                    active  <= 1'b1;
                    bit_cnt <= '0;
                    div_cnt <= '0;
                end
            end else begin
                if (div_cnt == mmio_pkg::uart_div_bits'(mmio_pkg::uart_divisor - 1)) begin
                    div_cnt <= '0;
                    bit_cnt <= bit_cnt + 4'd1;
                end else begin
                    div_cnt <= div_cnt + 1'b1;
                end
                // A start bit that is high again by mid period was a glitch.
                if (sample && bit_cnt == 4'd0 && rx_sync[1])
                    active <= 1'b0;
                if (sample && bit_cnt == 4'd9) begin
                    active          <= 1'b0;
                    uart_rx_pending <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample && bit_cnt >= 4'd1 && bit_cnt <= 4'd8)
            shift <= {rx_sync[1], shift[7:1]};
        if (sample && bit_cnt == 4'd9)
            rx_byte <= shift;
    end

    always_ff @(posedge clk) begin
        if (reset)
            resp_valid <= 1'b0;
        else
            resp_valid <= req_valid;
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            case (req_addr)
                4'h0:    resp_rdata <= {{(mmio_pkg::xlen-8){1'b0}}, rx_byte};
                4'h4:    resp_rdata <= {{(mmio_pkg::xlen-1){1'b0}}, uart_rx_pending};
                default: resp_rdata <= '0;
            endcase
        end
    end

endmodule

/* logic/uart_tx_port.sv */
module uart_tx_port (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        req_valid,
    output logic                        req_ready,
    input  logic                        req_wen,
    input  logic [7:0]                  req_wdata,
    output logic                        resp_valid,
    output logic [mmio_pkg::xlen-1:0]   resp_rdata,
    output logic                        uart_tx
);

    logic                               busy;
    logic [9:0]                         frame;
    logic [3:0]                         bit_cnt;
    logic [mmio_pkg::uart_div_bits-1:0] div_cnt;

    assign req_ready = !busy;
    assign uart_tx   = frame[0];

    //////////////////////////////////////////////////
    // Frame shifter
    //////////////////////////////////////////////////

    // The frame is stop bit, data and start bit, so it shifts out LSB first.
    always_ff @(posedge clk) begin
        if (reset) begin
            busy    <= 1'b0;
            frame   <= '1;
            bit_cnt <= '0;
            div_cnt <= '0;
        end else if (req_valid && req_wen) begin
            busy    <= 1'b1;
            frame   <= {1'b1, req_wdata, 1'b0};
            bit_cnt <= '0;
            div_cnt <= '0;
        end else if (busy) begin
            if (div_cnt == mmio_pkg::uart_div_bits'(mmio_pkg::uart_divisor - 1)) begin
                div_cnt <= '0;
                frame   <= {1'b1, frame[9:1]};
                bit_cnt <= bit_cnt + 4'd1;
                if (bit_cnt == 4'd9)
                    busy <= 1'b0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            resp_valid <= 1'b0;
        else
            resp_valid <= req_valid;
    end

    always_ff @(posedge clk) begin
        if (req_valid)
            resp_rdata <= {{(mmio_pkg::xlen-1){1'b0}}, busy};
    end

    no_start_while_busy: assert property (@(posedge clk) disable iff (reset)
        req_valid |-> !busy);

endmodule

/* logic/data_ram.sv */
module data_ram (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          req_valid,
    output logic                          req_ready,
    input  logic [mmio_pkg::xlen-1:0]     req_addr,
    input  logic                          req_wen,
    input  logic [mmio_pkg::xlen-1:0]     req_wdata,
    input  logic [mmio_pkg::xlen/8-1:0]   req_wmask,
    output logic                          resp_valid,
    output logic [mmio_pkg::xlen-1:0]     resp_rdata,
    output logic                          resp_error,
    output mmio_pkg::err_kind             resp_errty
);

    logic [mmio_pkg::xlen-1:0]              mem [mmio_pkg::ram_words];
    logic [$clog2(mmio_pkg::ram_words)-1:0] index;
    mmio_pkg::err_kind                      fault;

    assign req_ready = 1'b1;
    assign index     = req_addr[$clog2(mmio_pkg::ram_words)+1:2];

    always_comb begin
        if (req_addr[1:0] != 2'b00)
            fault = mmio_pkg::misaligned;
        else if (req_addr >= mmio_pkg::xlen'(mmio_pkg::ram_bytes))
            fault = mmio_pkg::access_fault;
        else
            fault = mmio_pkg::none;
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            if (req_wen && fault == mmio_pkg::none) begin
                for (int i = 0; i < mmio_pkg::xlen / 8; i++) begin
                    if (req_wmask[i])
                        mem[index][8*i +: 8] <= req_wdata[8*i +: 8];
                end
            end
            resp_rdata <= (fault == mmio_pkg::none) ? mem[index] : '0;
            resp_errty <= fault;
            resp_error <= (fault != mmio_pkg::none);
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            resp_valid <= 1'b0;
        else
            resp_valid <= req_valid;
    end

endmodule

/* logic/mmio_router.sv */
module mmio_router (
    input  logic                          clk,
    input  logic                          reset,

    input  logic                          dreq_valid,
    output logic                          dreq_ready,
    input  logic [mmio_pkg::xlen-1:0]     dreq_addr,
    input  logic                          dreq_wen,
    input  logic [mmio_pkg::xlen-1:0]     dreq_wdata,
    input  logic [mmio_pkg::xlen/8-1:0]   dreq_wmask,
    output logic                          dresp_valid,
    output logic [mmio_pkg::xlen-1:0]     dresp_rdata,
    output logic                          dresp_error,
    output mmio_pkg::err_kind             dresp_errty,

    output logic                          ram_start,
    input  logic                          ram_ready,
    input  logic                          ram_resp_valid,
    input  logic [mmio_pkg::xlen-1:0]     ram_resp_rdata,
    input  logic                          ram_error,
    input  mmio_pkg::err_kind             ram_errty,

    output logic                          tx_start,
    input  logic                          tx_ready,
    input  logic                          tx_resp_valid,
    input  logic [mmio_pkg::xlen-1:0]     tx_resp_rdata,

    output logic                          rx_start,
    input  logic                          rx_ready,
    input  logic                          rx_resp_valid,
    input  logic [mmio_pkg::xlen-1:0]     rx_resp_rdata,

    output logic                          timer_start,
    input  logic                          timer_ready,
    input  logic                          timer_resp_valid,
    input  logic [mmio_pkg::xlen-1:0]     timer_resp_rdata,

    output logic [mmio_pkg::xlen-1:0]     req_addr,
    output logic                          req_wen,
    output logic [mmio_pkg::xlen-1:0]     req_wdata,
    output logic [mmio_pkg::xlen/8-1:0]   req_wmask
);

    typedef enum logic [1:0] {
        idle,
        wait_ready,
        wait_valid
    } state_t;

    state_t                        state;
    logic [mmio_pkg::xlen-1:0]     s_addr;
    logic                          s_wen;
    logic [mmio_pkg::xlen-1:0]     s_wdata;
    logic [mmio_pkg::xlen/8-1:0]   s_wmask;

    // Select vectors hold one bit per target: ram, tx, rx, timer from bit 0 up.
    logic [3:0] sel;
    logic [3:0] s_sel;
    logic [3:0] ready_vec;
    logic [3:0] resp_vec;
    logic       cmd_ready;
    logic       cmd_start;
    logic       accept;

    function automatic logic [3:0] decode(input logic [mmio_pkg::xlen-1:0] addr);
        logic [3:0] hit;
        hit = 4'b0000;
        if (addr[mmio_pkg::xlen-1:2] == mmio_pkg::uart_tx_base[mmio_pkg::xlen-1:2])
            hit[1] = 1'b1;
        else if (addr[mmio_pkg::xlen-1:3] == mmio_pkg::uart_rx_base[mmio_pkg::xlen-1:3])
            hit[2] = 1'b1;
        else if (addr[mmio_pkg::xlen-1:4] == mmio_pkg::timer_base[mmio_pkg::xlen-1:4])
            hit[3] = 1'b1;
        else
            hit[0] = 1'b1;
        return hit;
    endfunction

    // While waiting for ready the held request is replayed, otherwise the live one goes out.
    assign req_addr  = (state == wait_ready) ? s_addr  : dreq_addr;
    assign req_wen   = (state == wait_ready) ? s_wen   : dreq_wen;
    assign req_wdata = (state == wait_ready) ? s_wdata : dreq_wdata;
    assign req_wmask = (state == wait_ready) ? s_wmask : dreq_wmask;

    assign sel       = decode(req_addr);
    assign ready_vec = {timer_ready, rx_ready, tx_ready, ram_ready};
    assign resp_vec  = {timer_resp_valid, rx_resp_valid, tx_resp_valid, ram_resp_valid};
    assign cmd_ready = |(sel & ready_vec);

    assign dresp_valid = |(s_sel & resp_vec);
    assign dreq_ready  = (state == idle) || (state == wait_valid && dresp_valid);
    assign accept      = dreq_valid && dreq_ready;
    assign cmd_start   = accept || (state == wait_ready);

    assign {timer_start, rx_start, tx_start, ram_start} = (cmd_start && cmd_ready) ? sel : 4'b0000;

    always_comb begin
        case (s_sel)
            4'b0001: dresp_rdata = ram_resp_rdata;
            4'b0010: dresp_rdata = tx_resp_rdata;
            4'b0100: dresp_rdata = rx_resp_rdata;
            4'b1000: dresp_rdata = timer_resp_rdata;
            default: dresp_rdata = '0;
        endcase
    end

    // Devices never fault. Only the RAM reports errors.
    assign dresp_error = s_sel[0] ? ram_error : 1'b0;
    assign dresp_errty = s_sel[0] ? ram_errty : mmio_pkg::none;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
            s_sel <= 4'b0000;
        end else if (accept) begin
            s_sel <= sel;
            state <= cmd_ready ? wait_valid : wait_ready;
        end else if (state == wait_ready && cmd_ready) begin
            state <= wait_valid;
        end else if (state == wait_valid && dresp_valid) begin
            state <= idle;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s_addr  <= dreq_addr;
            s_wen   <= dreq_wen;
            s_wdata <= dreq_wdata;
            s_wmask <= dreq_wmask;
        end
    end

    // Each start is answered in the next cycle, so only one request is ever in flight.
    one_in_flight: assert property (@(posedge clk) disable iff (reset)
        (ram_start || tx_start || rx_start || timer_start) |=> dresp_valid);

    // A target answers only after a start, so nothing may arrive while idle.
    no_resp_in_idle: assert property (@(posedge clk) disable iff (reset)
        (state == idle) |-> !dresp_valid);

endmodule

/* logic/mmio_pkg.sv */
package mmio_pkg;

    localparam int xlen = 32;

    localparam int ram_words = 1024;
    localparam int ram_bytes = ram_words * 4;

    //////////////////////////////////////////////////
    // Address map
    //////////////////////////////////////////////////

    // Addresses that miss every device window go to the RAM.
    localparam logic [xlen-1:0] uart_tx_base = 32'h1000_0000;
    localparam logic [xlen-1:0] uart_rx_base = 32'h1000_0010;
    localparam logic [xlen-1:0] timer_base   = 32'h0200_0000;

    // Clocks per UART bit.
    localparam int uart_divisor  = 4;
    localparam int uart_div_bits = $clog2(uart_divisor);

    typedef enum logic [1:0] {
        none,
        access_fault,
        misaligned
    } err_kind;

endpackage
